// File: common/ctrl_pkg.sv
package ctrl_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int ALU_OP_W   = 5;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000; // add, srl and the rest
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // sub, sra

    // RV32I major opcodes
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_AND    = 5'd0,
        ALU_OR     = 5'd1,
        ALU_ADD    = 5'd2,
        ALU_SUB    = 5'd3,
        ALU_SLL    = 5'd4,
        ALU_SRL    = 5'd5,
        ALU_SRA    = 5'd6,
        ALU_XOR    = 5'd7,
        ALU_PASS_B = 5'd8  // lui, immediate straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'd0,
        PC_TARGET = 2'd1, // taken branch or jalr
        PC_JAL    = 2'd2,
        PC_RESET  = 2'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE     = 2'd0,
        FWD_EXE_ALU  = 2'd1,
        FWD_MEM_ALU  = 2'd2,
        FWD_MEM_LOAD = 2'd3
    } fwd_sel_e;

    // branch conditions, signedness comes from compare_signed
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } branch_cond_e;

    typedef struct packed {
        logic    wreg;           // register file write
        logic    wmem;           // data memory write
        logic    mem2reg;        // writeback from memory
        alu_op_e alu_op;
        logic    aluimm;         // immediate as operand b
        logic    signext;
        logic    jal;            // link pc+4 into rd
        logic    jalr;
        logic    auipc;
        logic    slt_instr;
        logic    compare_signed;
        logic    compare_imm;
        logic    ls_b;           // byte access
        logic    ls_h;           // halfword access
        logic    load_signext;
    } ctrl_word_t;

    // state of an instruction further down the pipe
    typedef struct packed {
        logic                  wreg;
        logic                  mem2reg;
        logic [REG_ADDR_W-1:0] rd;
    } stage_info_t;

endpackage

// File: decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import ctrl_pkg::*;
(
    input  logic [XLEN-1:0]       i_instr,
    input  logic                  i_valid,
    output ctrl_word_t            o_ctrl,
    output logic                  o_use_rs1,
    output logic                  o_use_rs2,
    output logic [REG_ADDR_W-1:0] o_rs1,
    output logic [REG_ADDR_W-1:0] o_rs2,
    output branch_cond_e          o_br_cond,
    output pc_sel_e               o_jump_sel
);

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic                unknown; // word outside the kept subset

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    // base encodings, slt and sltu leave ALU_AND
    function automatic alu_op_e base_alu_op(input logic [FUNCT3_W-1:0] f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        o_ctrl     = '0;
        o_use_rs1  = 1'b0;
        o_use_rs2  = 1'b0;
        o_br_cond  = BR_NONE;
        o_jump_sel = PC_PLUS4;
        unknown    = 1'b0;
        case (opcode)
            OP:
            begin
                o_ctrl.wreg           = 1'b1;
                o_ctrl.alu_op         = base_alu_op(funct3);
                o_ctrl.slt_instr      = (funct3 == 3'b010) || (funct3 == 3'b011);
                o_ctrl.compare_signed = (funct3 == 3'b010);
                o_use_rs1             = 1'b1;
                o_use_rs2             = 1'b1;
                if (funct7 == F7_ALT)
                begin
                    case (funct3)
                        3'b000:  o_ctrl.alu_op = ALU_SUB;
                        3'b101:  o_ctrl.alu_op = ALU_SRA;
                        default: unknown = 1'b1;
                    endcase
                end
                else if (funct7 != F7_BASE)
                begin
                    unknown = 1'b1; // m extension and the rest
                end
            end
            OP_IMM:
            begin
                o_ctrl.wreg           = 1'b1;
                o_ctrl.alu_op         = base_alu_op(funct3);
                o_ctrl.aluimm         = 1'b1;
                o_ctrl.signext        = 1'b1;
                o_ctrl.slt_instr      = (funct3 == 3'b010) || (funct3 == 3'b011);
                o_ctrl.compare_signed = (funct3 == 3'b010);
                o_ctrl.compare_imm    = (funct3 == 3'b010) || (funct3 == 3'b011);
                o_use_rs1             = 1'b1;
                if ((funct3 == 3'b101) && (funct7 == F7_ALT))
                begin
                    o_ctrl.alu_op = ALU_SRA;
                end
                else if (((funct3 == 3'b001) || (funct3 == 3'b101)) && (funct7 != F7_BASE))
                begin
                    unknown = 1'b1; // upper shamt bits must be clean
                end
            end
            LOAD:
            begin
                o_ctrl.wreg         = 1'b1;
                o_ctrl.mem2reg      = 1'b1;
                o_ctrl.alu_op       = ALU_ADD;
                o_ctrl.aluimm       = 1'b1;
                o_ctrl.signext      = 1'b1;
                o_ctrl.ls_b         = (funct3[1:0] == 2'b00);
                o_ctrl.ls_h         = (funct3[1:0] == 2'b01);
                o_ctrl.load_signext = ~funct3[2] & ~funct3[1]; // lb and lh only
                o_use_rs1           = 1'b1;
                unknown             = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            STORE:
            begin
                o_ctrl.wmem    = 1'b1;
                o_ctrl.alu_op  = ALU_ADD;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                o_ctrl.ls_b    = (funct3 == 3'b000);
                o_ctrl.ls_h    = (funct3 == 3'b001);
                o_use_rs1      = 1'b1;
                o_use_rs2      = 1'b1;
                unknown        = funct3[2] || (funct3[1:0] == 2'b11);
            end
            BRANCH:
            begin
                o_ctrl.compare_signed = ~funct3[1]; // bltu and bgeu compare unsigned
                o_use_rs1             = 1'b1;
                o_use_rs2             = 1'b1;
                case (funct3)
                    3'b000:         o_br_cond = BR_EQ;
                    3'b001:         o_br_cond = BR_NE;
                    3'b100, 3'b110: o_br_cond = BR_LT;
                    3'b101, 3'b111: o_br_cond = BR_GE;
                    default:        unknown = 1'b1;
                endcase
            end
            LUI:
            begin
                o_ctrl.wreg   = 1'b1;
                o_ctrl.alu_op = ALU_PASS_B;
                o_ctrl.aluimm = 1'b1;
            end
            AUIPC:
            begin
                o_ctrl.wreg   = 1'b1;
                o_ctrl.alu_op = ALU_ADD;
                o_ctrl.aluimm = 1'b1;
                o_ctrl.auipc  = 1'b1;
            end
            JAL:
            begin
                o_ctrl.wreg = 1'b1;
                o_ctrl.jal  = 1'b1;
                o_jump_sel  = PC_JAL;
            end
            JALR:
            begin
                o_ctrl.wreg    = 1'b1;
                o_ctrl.alu_op  = ALU_ADD;
                o_ctrl.aluimm  = 1'b1;
                o_ctrl.signext = 1'b1;
                o_ctrl.jal     = 1'b1; // links like jal
                o_ctrl.jalr    = 1'b1;
                o_use_rs1      = 1'b1;
                o_jump_sel     = PC_TARGET;
                unknown        = (funct3 != 3'b000);
            end
            default:
            begin
                unknown = 1'b1;
            end
        endcase
        if (!i_valid || unknown)
        begin
            o_ctrl     = '0; // bubble
            o_use_rs1  = 1'b0;
            o_use_rs2  = 1'b0;
            o_br_cond  = BR_NONE;
            o_jump_sel = PC_PLUS4;
        end
    end

endmodule

// File: logic/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
    import ctrl_pkg::*;
(
    input  logic         i_resetn,
    input  branch_cond_e i_br_cond,
    input  pc_sel_e      i_jump_sel,
    input  logic         i_compare_lt,
    input  logic         i_compare_eq,
    output pc_sel_e      o_pc_sel,
    output logic         o_flush
);

    logic br_taken;

    // comparator already set up for signed or unsigned
    always_comb
    begin
        case (i_br_cond)
            BR_EQ:   br_taken = i_compare_eq;
            BR_NE:   br_taken = ~i_compare_eq;
            BR_LT:   br_taken = i_compare_lt;
            BR_GE:   br_taken = ~i_compare_lt;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb
    begin
        if (!i_resetn)
        begin
            o_pc_sel = PC_RESET; // fetch from the reset vector
        end
        else if (br_taken)
        begin
            o_pc_sel = PC_TARGET;
        end
        else
        begin
            o_pc_sel = i_jump_sel; // jal, jalr or pc+4
        end
    end

    // anything but pc+4 kills the fetched word
    assign o_flush = (o_pc_sel != PC_PLUS4);

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import ctrl_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_resetn,
    input  logic [XLEN-1:0] i_instr,
    input  logic            i_valid,
    input  logic            i_compare_lt,
    input  logic            i_compare_eq,
    input  stage_info_t     i_exe,
    input  stage_info_t     i_mem,
    output fwd_sel_e        o_fwd_a,
    output fwd_sel_e        o_fwd_b,
    output logic            o_not_stall,
    output pc_sel_e         o_pc_sel,
    output logic            o_flush,
    output ctrl_word_t      o_ctrl
);

    ctrl_word_t            dec_ctrl;
    ctrl_word_t            idex_next;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    branch_cond_e          br_cond;
    pc_sel_e               jump_sel;
    logic                  not_stall;

    instr_decoder u_instr_decoder (
        .i_instr    (i_instr),
        .i_valid    (i_valid),
        .o_ctrl     (dec_ctrl),
        .o_use_rs1  (use_rs1),
        .o_use_rs2  (use_rs2),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_br_cond  (br_cond),
        .o_jump_sel (jump_sel)
    );

    hazard_unit u_hazard_unit (
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_use_rs1   (use_rs1),
        .i_use_rs2   (use_rs2),
        .i_exe       (i_exe),
        .i_mem       (i_mem),
        .o_fwd_a     (o_fwd_a),
        .o_fwd_b     (o_fwd_b),
        .o_not_stall (not_stall)
    );

    branch_resolve u_branch_resolve (
        .i_resetn     (i_resetn),
        .i_br_cond    (br_cond),
        .i_jump_sel   (jump_sel),
        .i_compare_lt (i_compare_lt),
        .i_compare_eq (i_compare_eq),
        .o_pc_sel     (o_pc_sel),
        .o_flush      (o_flush)
    );

    // stalled word becomes a bubble, other fields kept
    always_comb
    begin
        idex_next      = dec_ctrl;
        idex_next.wreg = dec_ctrl.wreg & not_stall;
        idex_next.wmem = dec_ctrl.wmem & not_stall;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_resetn)
        begin
            o_ctrl <= '0; // no writes out of reset
        end
        else
        begin
            o_ctrl <= idex_next;
        end
    end

    assign o_not_stall = not_stall;

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import ctrl_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] i_rs1,
    input  logic [REG_ADDR_W-1:0] i_rs2,
    input  logic                  i_use_rs1,
    input  logic                  i_use_rs2,
    input  stage_info_t           i_exe,
    input  stage_info_t           i_mem,
    output fwd_sel_e              o_fwd_a,
    output fwd_sel_e              o_fwd_b,
    output logic                  o_not_stall
);

    logic exe_load_hit; // exe load targets a used source

    // first match wins, exe before mem, mem alu before mem load
    function automatic fwd_sel_e fwd_pick(
        input logic [REG_ADDR_W-1:0] rs,
        input stage_info_t           exe,
        input stage_info_t           mem
    );
        logic exe_hit;
        logic mem_hit;
        exe_hit = exe.wreg && (exe.rd != '0) && (exe.rd == rs);
        mem_hit = mem.wreg && (mem.rd != '0) && (mem.rd == rs);
        if (exe_hit && !exe.mem2reg)
        begin
            return FWD_EXE_ALU;
        end
        else if (mem_hit && !mem.mem2reg)
        begin
            return FWD_MEM_ALU;
        end
        else if (mem_hit && mem.mem2reg)
        begin
            return FWD_MEM_LOAD;
        end
        return FWD_NONE;
    endfunction

    always_comb
    begin
        o_fwd_a = fwd_pick(i_rs1, i_exe, i_mem);
        o_fwd_b = fwd_pick(i_rs2, i_exe, i_mem);
    end

    // load result not ready until mem, so hold decode one cycle
    always_comb
    begin
        exe_load_hit = 1'b0;
        if (i_exe.wreg && i_exe.mem2reg && (i_exe.rd != '0))
        begin
            exe_load_hit = (i_use_rs1 && (i_exe.rd == i_rs1)) ||
                           (i_use_rs2 && (i_exe.rd == i_rs2));
        end
    end

    assign o_not_stall = ~exe_load_hit;

endmodule

// File: run_sim.sh
#!/bin/sh
# builds and runs the control unit testbench under Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_control_unit \
    -o tb_control_unit > build.log 2>&1 \
    && ./obj_dir/tb_control_unit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; } || { echo "RESULT: PASS"; exit 0; }

// File: testbench/control_stim.txt
# name instr valid lt eq exe mem | expected fwd_a fwd_b not_stall pc_sel flush ctrl
# all fields after the name in hex, exe and mem are {wreg, mem2reg, rd[4:0]}
after_reset 00000000 0 0 0 00 00 0 0 1 0 0 00000
add 002081B3 1 0 0 00 00 0 0 1 0 0 41000
sub 402081B3 1 0 0 00 00 0 0 1 0 0 41800
sll 002091B3 1 0 0 00 00 0 0 1 0 0 42000
srl 0020D1B3 1 0 0 00 00 0 0 1 0 0 42800
sra 4020D1B3 1 0 0 00 00 0 0 1 0 0 43000
xor 0020C1B3 1 0 0 00 00 0 0 1 0 0 43800
or 0020E1B3 1 0 0 00 00 0 0 1 0 0 40800
and 0020F1B3 1 0 0 00 00 0 0 1 0 0 40000
slt 0020A1B3 1 0 0 00 00 0 0 1 0 0 40030
sltu 0020B1B3 1 0 0 00 00 0 0 1 0 0 40020
addi 00508193 1 0 0 00 00 0 0 1 0 0 41600
slti 0050A193 1 0 0 00 00 0 0 1 0 0 40638
sltiu 0050B193 1 0 0 00 00 0 0 1 0 0 40628
xori 0050C193 1 0 0 00 00 0 0 1 0 0 43E00
ori 0050E193 1 0 0 00 00 0 0 1 0 0 40E00
andi 0050F193 1 0 0 00 00 0 0 1 0 0 40600
slli 00509193 1 0 0 00 00 0 0 1 0 0 42600
srli 0050D193 1 0 0 00 00 0 0 1 0 0 42E00
srai 4050D193 1 0 0 00 00 0 0 1 0 0 43600
lb 00808183 1 0 0 00 00 0 0 1 0 0 51605
lh 00809183 1 0 0 00 00 0 0 1 0 0 51603
lw 0080A183 1 0 0 00 00 0 0 1 0 0 51600
lbu 0080C183 1 0 0 00 00 0 0 1 0 0 51604
lhu 0080D183 1 0 0 00 00 0 0 1 0 0 51602
sb 00208423 1 0 0 00 00 0 0 1 0 0 21604
sh 00209423 1 0 0 00 00 0 0 1 0 0 21602
sw 0020A423 1 0 0 00 00 0 0 1 0 0 21600
lui 123451B7 1 0 0 00 00 0 0 1 0 0 44400
auipc 00001197 1 0 0 00 00 0 0 1 0 0 41440
jal 010000EF 1 0 0 00 00 0 0 1 2 1 40100
jalr 000280E7 1 1 1 00 00 0 0 1 1 1 41780
beq_taken 00208463 1 0 1 00 00 0 0 1 1 1 00010
beq_not 00208463 1 0 0 00 00 0 0 1 0 0 00010
bne_taken 00209463 1 0 0 00 00 0 0 1 1 1 00010
bne_not 00209463 1 0 1 00 00 0 0 1 0 0 00010
blt_taken 0020C463 1 1 0 00 00 0 0 1 1 1 00010
blt_not 0020C463 1 0 0 00 00 0 0 1 0 0 00010
bge_taken 0020D463 1 0 0 00 00 0 0 1 1 1 00010
bge_equal 0020D463 1 0 1 00 00 0 0 1 1 1 00010
bge_not 0020D463 1 1 0 00 00 0 0 1 0 0 00010
bltu_taken 0020E463 1 1 0 00 00 0 0 1 1 1 00000
bltu_not 0020E463 1 0 1 00 00 0 0 1 0 0 00000
bgeu_taken 0020F463 1 0 0 00 00 0 0 1 1 1 00000
bgeu_not 0020F463 1 1 0 00 00 0 0 1 0 0 00000
fwd_exe_first 002081B3 1 0 0 41 41 1 0 1 0 0 41000
fwd_mem_alu 002081B3 1 0 0 00 41 2 0 1 0 0 41000
fwd_mem_load 002081B3 1 0 0 00 61 3 0 1 0 0 41000
fwd_exe_load 002081B3 1 0 0 61 41 2 0 0 0 0 01000
fwd_rd_zero 002001B3 1 0 0 40 40 0 0 1 0 0 41000
fwd_rs2 002081B3 1 0 0 42 61 3 1 1 0 0 41000
fwd_rs2_mem 002081B3 1 0 0 00 42 0 2 1 0 0 41000
stall_add 002081B3 1 0 0 61 00 0 0 0 0 0 01000
stall_store 0020A423 1 0 0 62 00 0 0 0 0 0 01600
nostall_lui 123451B7 1 0 0 68 00 0 0 1 0 0 44400
bubble_invalid 002081B3 0 0 0 61 00 0 0 1 0 0 00000
bubble_unknown 0020807F 1 0 0 61 00 0 0 1 0 0 00000
bubble_mul 022081B3 1 0 0 61 00 0 0 1 0 0 00000

// File: testbench/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit
    import ctrl_pkg::*;
();

    localparam int RESET_CYCLES  = 10;
    localparam int RELEASE_LIMIT = 20;   // cycles for pc_sel to leave the reset vector
    localparam int MAX_VECTORS   = 512;
    localparam int NAME_W        = 8 * 16;

    logic            clk;
    logic            resetn;
    logic [XLEN-1:0] instr;
    logic            valid;
    logic            compare_lt;
    logic            compare_eq;
    stage_info_t     exe_info;
    stage_info_t     mem_info;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic            not_stall;
    pc_sel_e         pc_sel;
    logic            flush;
    ctrl_word_t      ctrl;

    // fields of the current stim line
    logic [NAME_W-1:0]               test_name;
    logic [XLEN-1:0]                 v_instr;
    logic                            v_valid;
    logic                            v_lt;
    logic                            v_eq;
    logic [$bits(stage_info_t)-1:0]  v_exe;
    logic [$bits(stage_info_t)-1:0]  v_mem;
    logic [1:0]                      exp_fwd_a;
    logic [1:0]                      exp_fwd_b;
    logic                            exp_not_stall;
    logic [1:0]                      exp_pc_sel;
    logic                            exp_flush;
    logic [$bits(ctrl_word_t)-1:0]   exp_ctrl;

    int test_errors;
    int n_tests;
    int n_failed;
    bit stim_ok;
    bit release_ok;

    control_unit i_control_unit (
        .i_clk        (clk),
        .i_resetn     (resetn),
        .i_instr      (instr),
        .i_valid      (valid),
        .i_compare_lt (compare_lt),
        .i_compare_eq (compare_eq),
        .i_exe        (exe_info),
        .i_mem        (mem_info),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b),
        .o_not_stall  (not_stall),
        .o_pc_sel     (pc_sel),
        .o_flush      (flush),
        .o_ctrl       (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk; // 8 ns period
        end
    end

    task automatic check_value(
        input string       field,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected)
        else
        begin
            $display("Mismatch %0s %0s: expected %0h actual %0h",
                     test_name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        n_tests++;
        if (test_errors == 0)
        begin
            $display("PASS %0s", test_name);
        end
        else
        begin
            $display("FAIL %0s with %0d wrong values", test_name, test_errors);
            n_failed++;
        end
    endtask

    task automatic run_reset(output bit released);
        int cycle;
        int waited;
        test_name   = NAME_W'("reset");
        test_errors = 0;
        instr       = 32'h002081B3; // add x3, x1, x2 held through reset
        valid       = 1'b1;
        for (cycle = 0; cycle < RESET_CYCLES; cycle++)
        begin
            @(posedge clk);
            #1;
            check_value("pc_sel", 32'(PC_RESET), 32'(pc_sel));
            check_value("flush", 32'd1, 32'(flush));
            check_value("ctrl", 32'd0, 32'(ctrl)); // cleared from the first edge on
        end
        resetn = 1'b1;
        instr  = '0;
        valid  = 1'b0;
        waited = 0;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while ((pc_sel === PC_RESET) && (waited < RELEASE_LIMIT));
        released = (pc_sel !== PC_RESET);
        if (released)
        begin
            check_value("pc_sel", 32'(PC_PLUS4), 32'(pc_sel)); // valid low
            check_value("flush", 32'd0, 32'(flush));
            close_test();
        end
    endtask

    // one vector: drive, check comb outputs, then the registered word
    task automatic apply_vector();
        test_errors = 0;
        instr       = v_instr;
        valid       = v_valid;
        compare_lt  = v_lt;
        compare_eq  = v_eq;
        exe_info    = v_exe;
        mem_info    = v_mem;
        #5; // next edge 2 ns away
        check_value("fwd_a", 32'(exp_fwd_a), 32'(fwd_a));
        check_value("fwd_b", 32'(exp_fwd_b), 32'(fwd_b));
        check_value("not_stall", 32'(exp_not_stall), 32'(not_stall));
        check_value("pc_sel", 32'(exp_pc_sel), 32'(pc_sel));
        check_value("flush", 32'(exp_flush), 32'(flush));
        @(posedge clk);
        #1;
        check_value("ctrl", 32'(exp_ctrl), 32'(ctrl));
        close_test();
    endtask

    task automatic run_vectors(output bit ok);
        int    fd;
        int    fields;
        int    count;
        string line;
        ok    = 1'b1;
        count = 0;
        fd    = $fopen("testbench/control_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open stim file testbench/control_stim.txt");
            ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd) && (count < MAX_VECTORS))
            begin
                line   = "";
                fields = $fgets(line, fd);
                if ((fields > 1) && (line.getc(0) != "#")) // skip blanks and comments
                begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                                     test_name, v_instr, v_valid, v_lt, v_eq, v_exe, v_mem,
                                     exp_fwd_a, exp_fwd_b, exp_not_stall, exp_pc_sel,
                                     exp_flush, exp_ctrl);
                    if (fields == 13)
                    begin
                        apply_vector();
                        count++;
                    end
                    else
                    begin
                        $display("malformed stim line: %0s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (count == 0)
            begin
                $display("no vectors found in the stim file");
                ok = 1'b0;
            end
        end
    endtask

    initial
    begin
        resetn      = 1'b0;
        instr       = '0;
        valid       = 1'b0;
        compare_lt  = 1'b0;
        compare_eq  = 1'b0;
        exe_info    = '0;
        mem_info    = '0;
        n_tests     = 0;
        n_failed    = 0;
        test_errors = 0;
        stim_ok     = 1'b0;
        run_reset(release_ok);
        if (!release_ok)
        begin
            $display("timeout: pc_sel still at the reset vector %0d cycles after release",
                     RELEASE_LIMIT);
            $display("tests failed");
            $finish;
        end
        else
        begin
            run_vectors(stim_ok);
            $display("tests run %0d, passed %0d, failed %0d",
                     n_tests, n_tests - n_failed, n_failed);
            if ((n_failed == 0) && stim_ok)
            begin
                $display("all tests passed");
            end
            else
            begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// File: verilog.f
common/ctrl_pkg.sv
decode/instr_decoder.sv
logic/hazard_unit.sv
logic/branch_resolve.sv
logic/control_unit.sv
testbench/tb_control_unit.sv
